/* soc_bus.f */
+incdir+common
common/soc_bus_pkg.sv
hw/bus_arbiter.sv
hw/axi_xbar.sv
hw/sram_slave.sv
hw/clint_slave.sv
hw/soc_bus_top.sv
verif/soc_bus_checker.sv
verif/tb_soc_bus.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_soc_bus -f soc_bus.f -o sim_soc_bus
./obj_dir/sim_soc_bus | tee sim.log

if grep -qx "NO ERRORS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* verif/tb_soc_bus.sv */
`include "soc_bus_config.svh"
`timescale 1ns/1ps
`default_nettype none

module tb_soc_bus
    import soc_bus_pkg::*;
();

    localparam int N_STEPS         = 18;
    localparam int WATCHDOG_CYCLES = N_STEPS * 40;
    localparam int IDX_W           = $clog2(`SOC_SRAM_WORDS);

    localparam logic       IFU = 1'b0;
    localparam logic       LSU = 1'b1;
    localparam logic       WR  = 1'b1;
    localparam logic       RD  = 1'b0;
    localparam logic [1:0] OK  = `SOC_RESP_OKAY;
    localparam logic [1:0] DE  = `SOC_RESP_DECERR;

    // how the expected read data is found
    localparam logic [1:0] K_EXACT  = 2'd0;
    localparam logic [1:0] K_SHADOW = 2'd1;
    localparam logic [1:0] K_RANGE  = 2'd2;

    typedef struct packed {
        logic        pair;
        logic        m;
        logic        wr;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [1:0]  resp;
        logic [1:0]  kind;
    } step_t;

    logic        clk;
    logic        rst_n;
    logic [1:0]  wr_valid;
    logic [1:0]  wr_ready;
    bus_wr_req_t wr_req [2];
    logic [1:0]  b_valid;
    logic [1:0]  b_ready = 2'b00;
    bus_wr_rsp_t b_rsp [2];
    logic [1:0]  rd_valid;
    logic [1:0]  rd_ready;
    bus_rd_req_t rd_req [2];
    logic [1:0]  r_valid;
    logic [1:0]  r_ready = 2'b00;
    bus_rd_rsp_t r_rsp [2];

    integer      seed = 32'h243150db;
    logic [31:0] rnd;
    step_t       steps [N_STEPS];
    logic [31:0] shadow [`SOC_SRAM_WORDS];

    soc_bus_top UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .ifu_wr_valid (wr_valid[0]),
        .ifu_wr_ready (wr_ready[0]),
        .ifu_wr_req   (wr_req[0]),
        .ifu_b_valid  (b_valid[0]),
        .ifu_b_ready  (b_ready[0]),
        .ifu_b_rsp    (b_rsp[0]),
        .ifu_rd_valid (rd_valid[0]),
        .ifu_rd_ready (rd_ready[0]),
        .ifu_rd_req   (rd_req[0]),
        .ifu_r_valid  (r_valid[0]),
        .ifu_r_ready  (r_ready[0]),
        .ifu_r_rsp    (r_rsp[0]),
        .lsu_wr_valid (wr_valid[1]),
        .lsu_wr_ready (wr_ready[1]),
        .lsu_wr_req   (wr_req[1]),
        .lsu_b_valid  (b_valid[1]),
        .lsu_b_ready  (b_ready[1]),
        .lsu_b_rsp    (b_rsp[1]),
        .lsu_rd_valid (rd_valid[1]),
        .lsu_rd_ready (rd_ready[1]),
        .lsu_rd_req   (rd_req[1]),
        .lsu_r_valid  (r_valid[1]),
        .lsu_r_ready  (r_ready[1]),
        .lsu_r_rsp    (r_rsp[1])
    );

    soc_bus_checker u_checker (
        .clk     (clk),
        .rst_n   (rst_n),
        .b_valid (b_valid),
        .b_ready (b_ready),
        .b_rsp   (b_rsp),
        .r_valid (r_valid),
        .r_ready (r_ready),
        .r_rsp   (r_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // random back-pressure on both response channels
    always @(negedge clk) begin
        rnd = $random(seed);
        b_ready = rnd[1:0];
        r_ready = rnd[5:4];
    end

    function automatic logic in_sram(input logic [31:0] addr);
        return addr >= `SOC_SRAM_BASE &&
               addr < (`SOC_SRAM_BASE + 32'(`SOC_SRAM_WORDS * 4));
    endfunction

    function automatic logic [31:0] apply_strobes(
        input logic [31:0] old_word,
        input logic [31:0] new_word,
        input logic [3:0]  strb
    );
        logic [31:0] mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    // the first pair also checks that the ifu wins the first tie
    task automatic fill_table();
        steps[0]  = '{1'b1, IFU, WR, 32'h8000_0010, 32'h1111_2222, 4'hf, OK, K_EXACT};
        steps[1]  = '{1'b1, LSU, WR, 32'h8000_0020, 32'h3333_4444, 4'hf, OK, K_EXACT};
        steps[2]  = '{1'b1, IFU, RD, 32'h8000_0020, 32'h0,         4'h0, OK, K_SHADOW};
        steps[3]  = '{1'b1, LSU, RD, 32'h8000_0010, 32'h0,         4'h0, OK, K_SHADOW};
        steps[4]  = '{1'b0, IFU, WR, 32'h8000_0000, 32'ha5a5_5a5a, 4'hf, OK, K_EXACT};
        steps[5]  = '{1'b0, LSU, WR, 32'h8000_0000, 32'h0000_bb00, 4'h2, OK, K_EXACT};
        steps[6]  = '{1'b0, IFU, RD, 32'h8000_0000, 32'h0,         4'h0, OK, K_SHADOW};
        steps[7]  = '{1'b0, LSU, WR, 32'h8000_0010, 32'hcc00_00dd, 4'h9, OK, K_EXACT};
        steps[8]  = '{1'b0, LSU, RD, 32'h8000_0010, 32'h0,         4'h0, OK, K_SHADOW};
        // just past the sram, aliases word 0 if it were routed there
        steps[9]  = '{1'b0, LSU, WR, 32'h8000_1000, 32'hdead_beef, 4'hf, DE, K_EXACT};
        steps[10] = '{1'b0, IFU, RD, 32'h9000_0000, 32'h0,         4'h0, DE, K_EXACT};
        steps[11] = '{1'b0, LSU, RD, 32'h8000_0000, 32'h0,         4'h0, OK, K_SHADOW};
        steps[12] = '{1'b0, LSU, WR, 32'ha000_0048, 32'h0000_1000, 4'hf, OK, K_EXACT};
        steps[13] = '{1'b1, IFU, RD, 32'ha000_0048, 32'h0000_1000, 4'h0, OK, K_RANGE};
        steps[14] = '{1'b1, LSU, RD, 32'h8000_0000, 32'h0,         4'h0, OK, K_SHADOW};
        steps[15] = '{1'b1, IFU, WR, 32'h8000_0030, 32'h7777_8888, 4'hf, OK, K_EXACT};
        steps[16] = '{1'b1, LSU, WR, 32'ha000_0050, 32'h1234_5678, 4'hf, DE, K_EXACT};
        steps[17] = '{1'b0, IFU, RD, 32'h8000_0030, 32'h0,         4'h0, OK, K_SHADOW};
    endtask

    task automatic run_step(input step_t s);
        logic [31:0] lo;
        logic [31:0] hi;
        if (s.wr) begin
            if (in_sram(s.addr)) begin
                shadow[s.addr[2 +: IDX_W]] =
                    apply_strobes(shadow[s.addr[2 +: IDX_W]], s.data, s.strb);
            end
            u_checker.expect_write(s.m, s.resp);
            @(negedge clk);
            wr_valid[s.m] = 1'b1;
            wr_req[s.m]   = '{addr: s.addr, data: s.data, strb: s.strb};
            do @(posedge clk); while (!wr_ready[s.m]);
            @(negedge clk);
            wr_valid[s.m] = 1'b0;
            do @(posedge clk); while (!(b_valid[s.m] && b_ready[s.m]));
        end else begin
            case (s.kind)
                K_SHADOW: begin
                    lo = shadow[s.addr[2 +: IDX_W]];
                    hi = lo;
                end
                // mtime keeps counting after the write
                K_RANGE: begin
                    lo = s.data;
                    hi = s.data + 32'(WATCHDOG_CYCLES);
                end
                default: begin
                    lo = s.data;
                    hi = s.data;
                end
            endcase
            u_checker.expect_read(s.m, s.resp, lo, hi);
            @(negedge clk);
            rd_valid[s.m] = 1'b1;
            rd_req[s.m]   = '{addr: s.addr};
            do @(posedge clk); while (!rd_ready[s.m]);
            @(negedge clk);
            rd_valid[s.m] = 1'b0;
            do @(posedge clk); while (!(r_valid[s.m] && r_ready[s.m]));
        end
    endtask

    initial begin
        int i;
        rst_n    = 1'b0;
        wr_valid = 2'b00;
        rd_valid = 2'b00;
        for (int m = 0; m < 2; m++) begin
            wr_req[m] = '0;
            rd_req[m] = '0;
        end
        fill_table();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        i = 0;
        while (i < N_STEPS) begin
            if (steps[i].pair) begin
                fork
                    run_step(steps[i]);
                    run_step(steps[i + 1]);
                join
                i = i + 2;
            end else begin
                run_step(steps[i]);
                i = i + 1;
            end
        end

        repeat (4) @(posedge clk);
        u_checker.report();
        if (u_checker.total_errors() == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the stimulus table did not finish within %0d cycles",
                 WATCHDOG_CYCLES);
        u_checker.report();
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/soc_bus_checker.sv */
`include "soc_bus_config.svh"
`timescale 1ns/1ps
`default_nettype none

module soc_bus_checker
    import soc_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic [1:0]  b_valid,
    input  logic [1:0]  b_ready,
    input  bus_wr_rsp_t b_rsp [2],
    input  logic [1:0]  r_valid,
    input  logic [1:0]  r_ready,
    input  bus_rd_rsp_t r_rsp [2]
);

    // exact match when lo equals hi
    typedef struct packed {
        logic [1:0]  resp;
        logic [31:0] lo;
        logic [31:0] hi;
    } rd_exp_t;

    logic [1:0] wr_exp [2][$];
    rd_exp_t    rd_exp [2][$];
    int         errors = 0;
    int         checked = 0;
    logic       first_b_seen = 1'b0;

    function automatic string who(input logic m);
        return m ? "lsu" : "ifu";
    endfunction

    task automatic expect_write(input logic m, input logic [1:0] resp);
        wr_exp[m].push_back(resp);
    endtask

    task automatic expect_read(
        input logic        m,
        input logic [1:0]  resp,
        input logic [31:0] lo,
        input logic [31:0] hi
    );
        rd_exp[m].push_back('{resp: resp, lo: lo, hi: hi});
    endtask

    task automatic check_write(input logic m);
        logic [1:0] exp_resp;
        if (wr_exp[m].size() == 0) begin
            $display("t=%0t: %s got a write response it never asked for", $time, who(m));
            errors++;
        end else begin
            exp_resp = wr_exp[m].pop_front();
            checked++;
            if (b_rsp[m].resp !== exp_resp) begin
                $display("CHECK FAILED t=%0t: %s write resp %0d, expected %0d",
                         $time, who(m), b_rsp[m].resp, exp_resp);
                errors++;
            end
        end
    endtask

    task automatic check_read(input logic m);
        rd_exp_t e;
        if (rd_exp[m].size() == 0) begin
            $display("t=%0t: %s got a read response it never asked for", $time, who(m));
            errors++;
        end else begin
            e = rd_exp[m].pop_front();
            checked++;
            if (r_rsp[m].resp !== e.resp || $isunknown(r_rsp[m].data) ||
                r_rsp[m].data < e.lo || r_rsp[m].data > e.hi) begin
                $display("CHECK FAILED t=%0t: %s read %h resp %0d, expected %h..%h resp %0d",
                         $time, who(m), r_rsp[m].data, r_rsp[m].resp, e.lo, e.hi, e.resp);
                errors++;
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            // stimulus opens with a paired write, ifu must own the first grant
            if (!first_b_seen && b_valid != 2'b00) begin
                first_b_seen = 1'b1;
                if (!b_valid[0]) begin
                    $display("CHECK FAILED t=%0t: first write grant went to the lsu", $time);
                    errors++;
                end
            end
            for (int m = 0; m < 2; m++) begin
                if (b_valid[m] && b_ready[m]) begin
                    check_write(1'(m));
                end
                if (r_valid[m] && r_ready[m]) begin
                    check_read(1'(m));
                end
            end
        end
    end

    function automatic int total_errors();
        return errors + wr_exp[0].size() + wr_exp[1].size()
                      + rd_exp[0].size() + rd_exp[1].size();
    endfunction

    task automatic report();
        int missing;
        missing = 0;
        for (int m = 0; m < 2; m++) begin
            if (wr_exp[m].size() != 0 || rd_exp[m].size() != 0) begin
                $display("%s never received %0d write and %0d read responses",
                         who(1'(m)), wr_exp[m].size(), rd_exp[m].size());
            end
            missing += wr_exp[m].size() + rd_exp[m].size();
        end
        $display("checker: %0d responses checked, %0d mismatches, %0d missing",
                 checked, errors, missing);
    endtask

endmodule

`default_nettype wire

/* hw/soc_bus_top.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_bus_top
    import soc_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    // instruction fetch master
    input  logic        ifu_wr_valid,
    output logic        ifu_wr_ready,
    input  bus_wr_req_t ifu_wr_req,
    output logic        ifu_b_valid,
    input  logic        ifu_b_ready,
    output bus_wr_rsp_t ifu_b_rsp,
    input  logic        ifu_rd_valid,
    output logic        ifu_rd_ready,
    input  bus_rd_req_t ifu_rd_req,
    output logic        ifu_r_valid,
    input  logic        ifu_r_ready,
    output bus_rd_rsp_t ifu_r_rsp,

    // load/store master
    input  logic        lsu_wr_valid,
    output logic        lsu_wr_ready,
    input  bus_wr_req_t lsu_wr_req,
    output logic        lsu_b_valid,
    input  logic        lsu_b_ready,
    output bus_wr_rsp_t lsu_b_rsp,
    input  logic        lsu_rd_valid,
    output logic        lsu_rd_ready,
    input  bus_rd_req_t lsu_rd_req,
    output logic        lsu_r_valid,
    input  logic        lsu_r_ready,
    output bus_rd_rsp_t lsu_r_rsp
);

    // arbiter to crossbar
    logic        x_wr_valid;
    logic        x_wr_ready;
    bus_wr_req_t x_wr_req;
    logic        x_b_valid;
    logic        x_b_ready;
    bus_wr_rsp_t x_b_rsp;
    logic        x_rd_valid;
    logic        x_rd_ready;
    bus_rd_req_t x_rd_req;
    logic        x_r_valid;
    logic        x_r_ready;
    bus_rd_rsp_t x_r_rsp;

    // crossbar to sram
    logic        s_wr_valid;
    logic        s_wr_ready;
    bus_wr_req_t s_wr_req;
    logic        s_b_valid;
    logic        s_b_ready;
    bus_wr_rsp_t s_b_rsp;
    logic        s_rd_valid;
    logic        s_rd_ready;
    bus_rd_req_t s_rd_req;
    logic        s_r_valid;
    logic        s_r_ready;
    bus_rd_rsp_t s_r_rsp;

    // crossbar to clint
    logic        c_wr_valid;
    logic        c_wr_ready;
    bus_wr_req_t c_wr_req;
    logic        c_b_valid;
    logic        c_b_ready;
    bus_wr_rsp_t c_b_rsp;
    logic        c_rd_valid;
    logic        c_rd_ready;
    bus_rd_req_t c_rd_req;
    logic        c_r_valid;
    logic        c_r_ready;
    bus_rd_rsp_t c_r_rsp;

    // the valid tells each master whether the payload is its own
    assign ifu_b_rsp = x_b_rsp;
    assign lsu_b_rsp = x_b_rsp;
    assign ifu_r_rsp = x_r_rsp;
    assign lsu_r_rsp = x_r_rsp;

    bus_arbiter #(.req_t(bus_wr_req_t)) u_wr_arb (
        .clk         (clk),
        .rst_n       (rst_n),
        .m_valid     ({lsu_wr_valid, ifu_wr_valid}),
        .m_ready     ({lsu_wr_ready, ifu_wr_ready}),
        .m_req       ({lsu_wr_req, ifu_wr_req}),
        .s_valid     (x_wr_valid),
        .s_ready     (x_wr_ready),
        .s_req       (x_wr_req),
        .rsp_valid   (x_b_valid),
        .rsp_ready   (x_b_ready),
        .m_rsp_valid ({lsu_b_valid, ifu_b_valid}),
        .m_rsp_ready ({lsu_b_ready, ifu_b_ready})
    );

    bus_arbiter #(.req_t(bus_rd_req_t)) u_rd_arb (
        .clk         (clk),
        .rst_n       (rst_n),
        .m_valid     ({lsu_rd_valid, ifu_rd_valid}),
        .m_ready     ({lsu_rd_ready, ifu_rd_ready}),
        .m_req       ({lsu_rd_req, ifu_rd_req}),
        .s_valid     (x_rd_valid),
        .s_ready     (x_rd_ready),
        .s_req       (x_rd_req),
        .rsp_valid   (x_r_valid),
        .rsp_ready   (x_r_ready),
        .m_rsp_valid ({lsu_r_valid, ifu_r_valid}),
        .m_rsp_ready ({lsu_r_ready, ifu_r_ready})
    );

    axi_xbar u_xbar (
        .clk            (clk),
        .rst_n          (rst_n),
        .wr_valid       (x_wr_valid),
        .wr_ready       (x_wr_ready),
        .wr_req         (x_wr_req),
        .b_valid        (x_b_valid),
        .b_ready        (x_b_ready),
        .b_rsp          (x_b_rsp),
        .rd_valid       (x_rd_valid),
        .rd_ready       (x_rd_ready),
        .rd_req         (x_rd_req),
        .r_valid        (x_r_valid),
        .r_ready        (x_r_ready),
        .r_rsp          (x_r_rsp),
        .sram_wr_valid  (s_wr_valid),
        .sram_wr_ready  (s_wr_ready),
        .sram_wr_req    (s_wr_req),
        .sram_b_valid   (s_b_valid),
        .sram_b_ready   (s_b_ready),
        .sram_b_rsp     (s_b_rsp),
        .sram_rd_valid  (s_rd_valid),
        .sram_rd_ready  (s_rd_ready),
        .sram_rd_req    (s_rd_req),
        .sram_r_valid   (s_r_valid),
        .sram_r_ready   (s_r_ready),
        .sram_r_rsp     (s_r_rsp),
        .clint_wr_valid (c_wr_valid),
        .clint_wr_ready (c_wr_ready),
        .clint_wr_req   (c_wr_req),
        .clint_b_valid  (c_b_valid),
        .clint_b_ready  (c_b_ready),
        .clint_b_rsp    (c_b_rsp),
        .clint_rd_valid (c_rd_valid),
        .clint_rd_ready (c_rd_ready),
        .clint_rd_req   (c_rd_req),
        .clint_r_valid  (c_r_valid),
        .clint_r_ready  (c_r_ready),
        .clint_r_rsp    (c_r_rsp)
    );

    sram_slave u_sram (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_valid (s_wr_valid),
        .wr_ready (s_wr_ready),
        .wr_req   (s_wr_req),
        .b_valid  (s_b_valid),
        .b_ready  (s_b_ready),
        .b_rsp    (s_b_rsp),
        .rd_valid (s_rd_valid),
        .rd_ready (s_rd_ready),
        .rd_req   (s_rd_req),
        .r_valid  (s_r_valid),
        .r_ready  (s_r_ready),
        .r_rsp    (s_r_rsp)
    );

    clint_slave u_clint (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_valid (c_wr_valid),
        .wr_ready (c_wr_ready),
        .wr_req   (c_wr_req),
        .b_valid  (c_b_valid),
        .b_ready  (c_b_ready),
        .b_rsp    (c_b_rsp),
        .rd_valid (c_rd_valid),
        .rd_ready (c_rd_ready),
        .rd_req   (c_rd_req),
        .r_valid  (c_r_valid),
        .r_ready  (c_r_ready),
        .r_rsp    (c_r_rsp)
    );

endmodule

`default_nettype wire

/* hw/clint_slave.sv */
`include "soc_bus_config.svh"
`timescale 1ns/1ps
`default_nettype none

module clint_slave
    import soc_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wr_valid,
    output logic        wr_ready,
    input  bus_wr_req_t wr_req,
    output logic        b_valid,
    input  logic        b_ready,
    output bus_wr_rsp_t b_rsp,
    input  logic        rd_valid,
    output logic        rd_ready,
    input  bus_rd_req_t rd_req,
    output logic        r_valid,
    input  logic        r_ready,
    output bus_rd_rsp_t r_rsp
);

    logic [63:0] mtime;
    logic [31:0] rd_data;
    logic [31:0] wr_off;
    logic [31:0] rd_off;
    logic        wr_fire;
    logic        rd_fire;

    // bit 2 of the offset picks the high word
    assign wr_off = wr_req.addr - `SOC_CLINT_BASE;
    assign rd_off = rd_req.addr - `SOC_CLINT_BASE;

    assign wr_ready = !b_valid;
    assign rd_ready = !r_valid;
    assign wr_fire  = wr_valid && wr_ready;
    assign rd_fire  = rd_valid && rd_ready;

    assign b_rsp = '{resp: `SOC_RESP_OKAY};
    assign r_rsp = '{data: rd_data, resp: `SOC_RESP_OKAY};

    // snapshot at acceptance
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rd_data <= rd_off[2] ? mtime[63:32] : mtime[31:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime   <= 64'd0;
            b_valid <= 1'b0;
            r_valid <= 1'b0;
        end else begin
            // a write cycle replaces the tick
            if (wr_fire && wr_off[2]) begin
                mtime[63:32] <= strb_merge(mtime[63:32], wr_req.data, wr_req.strb);
            end else if (wr_fire) begin
                mtime[31:0] <= strb_merge(mtime[31:0], wr_req.data, wr_req.strb);
            end else begin
                mtime <= mtime + 64'd1;
            end
            if (wr_fire) begin
                b_valid <= 1'b1;
            end else if (b_ready) begin
                b_valid <= 1'b0;
            end
            if (rd_fire) begin
                r_valid <= 1'b1;
            end else if (r_ready) begin
                r_valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/sram_slave.sv */
`include "soc_bus_config.svh"
`timescale 1ns/1ps
`default_nettype none

module sram_slave
    import soc_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wr_valid,
    output logic        wr_ready,
    input  bus_wr_req_t wr_req,
    output logic        b_valid,
    input  logic        b_ready,
    output bus_wr_rsp_t b_rsp,
    input  logic        rd_valid,
    output logic        rd_ready,
    input  bus_rd_req_t rd_req,
    output logic        r_valid,
    input  logic        r_ready,
    output bus_rd_rsp_t r_rsp
);

    localparam int IDX_W = $clog2(`SOC_SRAM_WORDS);

    logic [31:0]      mem [`SOC_SRAM_WORDS];
    logic [31:0]      rd_data;
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;
    logic             wr_fire;
    logic             rd_fire;

    // word index wraps inside the array
    assign wr_idx  = wr_req.addr[2 +: IDX_W];
    assign rd_idx  = rd_req.addr[2 +: IDX_W];

    // one response in flight per channel
    assign wr_ready = !b_valid;
    assign rd_ready = !r_valid;
    assign wr_fire  = wr_valid && wr_ready;
    assign rd_fire  = rd_valid && rd_ready;

    assign b_rsp = '{resp: `SOC_RESP_OKAY};
    assign r_rsp = '{data: rd_data, resp: `SOC_RESP_OKAY};

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[wr_idx] <= strb_merge(mem[wr_idx], wr_req.data, wr_req.strb);
        end
        if (rd_fire) begin
            rd_data <= mem[rd_idx];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            b_valid <= 1'b0;
            r_valid <= 1'b0;
        end else begin
            if (wr_fire) begin
                b_valid <= 1'b1;
            end else if (b_ready) begin
                b_valid <= 1'b0;
            end
            if (rd_fire) begin
                r_valid <= 1'b1;
            end else if (r_ready) begin
                r_valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/axi_xbar.sv */
`include "soc_bus_config.svh"
`timescale 1ns/1ps
`default_nettype none

module axi_xbar
    import soc_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    // from the arbiters
    input  logic        wr_valid,
    output logic        wr_ready,
    input  bus_wr_req_t wr_req,
    output logic        b_valid,
    input  logic        b_ready,
    output bus_wr_rsp_t b_rsp,
    input  logic        rd_valid,
    output logic        rd_ready,
    input  bus_rd_req_t rd_req,
    output logic        r_valid,
    input  logic        r_ready,
    output bus_rd_rsp_t r_rsp,

    // sram target
    output logic        sram_wr_valid,
    input  logic        sram_wr_ready,
    output bus_wr_req_t sram_wr_req,
    input  logic        sram_b_valid,
    output logic        sram_b_ready,
    input  bus_wr_rsp_t sram_b_rsp,
    output logic        sram_rd_valid,
    input  logic        sram_rd_ready,
    output bus_rd_req_t sram_rd_req,
    input  logic        sram_r_valid,
    output logic        sram_r_ready,
    input  bus_rd_rsp_t sram_r_rsp,

    // clint target
    output logic        clint_wr_valid,
    input  logic        clint_wr_ready,
    output bus_wr_req_t clint_wr_req,
    input  logic        clint_b_valid,
    output logic        clint_b_ready,
    input  bus_wr_rsp_t clint_b_rsp,
    output logic        clint_rd_valid,
    input  logic        clint_rd_ready,
    output bus_rd_req_t clint_rd_req,
    input  logic        clint_r_valid,
    output logic        clint_r_ready,
    input  bus_rd_rsp_t clint_r_rsp
);

    localparam logic [1:0]  TGT_SRAM  = 2'd0;
    localparam logic [1:0]  TGT_CLINT = 2'd1;
    localparam logic [1:0]  TGT_NONE  = 2'd2;
    localparam logic [31:0] SRAM_END  = `SOC_SRAM_BASE + 32'(`SOC_SRAM_WORDS * 4);
    localparam logic [31:0] CLINT_END = `SOC_CLINT_BASE + 32'd8;

    logic [1:0] wr_sel;
    logic [1:0] rd_sel;
    logic [1:0] wr_tgt;
    logic [1:0] rd_tgt;
    logic       wr_busy;
    logic       rd_busy;

    function automatic logic [1:0] decode(input logic [31:0] addr);
        if (addr >= `SOC_SRAM_BASE && addr < SRAM_END) begin
            return TGT_SRAM;
        end else if (addr >= `SOC_CLINT_BASE && addr < CLINT_END) begin
            return TGT_CLINT;
        end
        return TGT_NONE;
    endfunction

    assign wr_sel = decode(wr_req.addr);
    assign rd_sel = decode(rd_req.addr);

    // request steering, no register on the way
    assign sram_wr_valid  = wr_valid && !wr_busy && (wr_sel == TGT_SRAM);
    assign clint_wr_valid = wr_valid && !wr_busy && (wr_sel == TGT_CLINT);
    assign sram_rd_valid  = rd_valid && !rd_busy && (rd_sel == TGT_SRAM);
    assign clint_rd_valid = rd_valid && !rd_busy && (rd_sel == TGT_CLINT);
    assign sram_wr_req    = wr_req;
    assign clint_wr_req   = wr_req;
    assign sram_rd_req    = rd_req;
    assign clint_rd_req   = rd_req;

    // unmapped requests are taken here
    always_comb begin
        case (wr_sel)
            TGT_SRAM:  wr_ready = !wr_busy && sram_wr_ready;
            TGT_CLINT: wr_ready = !wr_busy && clint_wr_ready;
            default:   wr_ready = !wr_busy;
        endcase
        case (rd_sel)
            TGT_SRAM:  rd_ready = !rd_busy && sram_rd_ready;
            TGT_CLINT: rd_ready = !rd_busy && clint_rd_ready;
            default:   rd_ready = !rd_busy;
        endcase
    end

    // response mux follows the recorded target
    always_comb begin
        b_valid = 1'b0;
        b_rsp   = '{resp: `SOC_RESP_DECERR};
        if (wr_busy) begin
            case (wr_tgt)
                TGT_SRAM: begin
                    b_valid = sram_b_valid;
                    b_rsp   = sram_b_rsp;
                end
                TGT_CLINT: begin
                    b_valid = clint_b_valid;
                    b_rsp   = clint_b_rsp;
                end
                default: b_valid = 1'b1;
            endcase
        end
    end

    always_comb begin
        r_valid = 1'b0;
        r_rsp   = '{data: 32'h0, resp: `SOC_RESP_DECERR};
        if (rd_busy) begin
            case (rd_tgt)
                TGT_SRAM: begin
                    r_valid = sram_r_valid;
                    r_rsp   = sram_r_rsp;
                end
                TGT_CLINT: begin
                    r_valid = clint_r_valid;
                    r_rsp   = clint_r_rsp;
                end
                default: r_valid = 1'b1;
            endcase
        end
    end

    assign sram_b_ready  = b_ready && wr_busy && (wr_tgt == TGT_SRAM);
    assign clint_b_ready = b_ready && wr_busy && (wr_tgt == TGT_CLINT);
    assign sram_r_ready  = r_ready && rd_busy && (rd_tgt == TGT_SRAM);
    assign clint_r_ready = r_ready && rd_busy && (rd_tgt == TGT_CLINT);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_busy <= 1'b0;
            wr_tgt  <= TGT_SRAM;
            rd_busy <= 1'b0;
            rd_tgt  <= TGT_SRAM;
        end else begin
            if (wr_valid && wr_ready) begin
                wr_busy <= 1'b1;
                wr_tgt  <= wr_sel;
            end else if (b_valid && b_ready) begin
                wr_busy <= 1'b0;
            end
            if (rd_valid && rd_ready) begin
                rd_busy <= 1'b1;
                rd_tgt  <= rd_sel;
            end else if (r_valid && r_ready) begin
                rd_busy <= 1'b0;
            end
        end
    end

    // a target only answers a request routed to it
    assert property (@(posedge clk) disable iff (!rst_n)
        sram_b_valid |-> wr_busy && wr_tgt == TGT_SRAM);
    assert property (@(posedge clk) disable iff (!rst_n)
        clint_b_valid |-> wr_busy && wr_tgt == TGT_CLINT);
    assert property (@(posedge clk) disable iff (!rst_n)
        sram_r_valid |-> rd_busy && rd_tgt == TGT_SRAM);
    assert property (@(posedge clk) disable iff (!rst_n)
        clint_r_valid |-> rd_busy && rd_tgt == TGT_CLINT);

endmodule

`default_nettype wire

/* hw/bus_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter
    import soc_bus_pkg::*;
#(
    parameter type req_t = bus_rd_req_t
)(
    input  logic       clk,
    input  logic       rst_n,

    // master side, index 0 is ifu and index 1 is lsu
    input  logic [1:0] m_valid,
    output logic [1:0] m_ready,
    input  req_t [1:0] m_req,

    // towards the crossbar
    output logic       s_valid,
    input  logic       s_ready,
    output req_t       s_req,

    // response handshake, payload is fanned out at the top level
    input  logic       rsp_valid,
    output logic       rsp_ready,
    output logic [1:0] m_rsp_valid,
    input  logic [1:0] m_rsp_ready
);

    logic busy;
    // current owner, doubles as the last grant for round robin
    logic owner;
    logic pick;
    logic accept;
    logic rsp_done;

    // on a tie the master that did not own last wins
    always_comb begin
        if (m_valid == 2'b11) begin
            pick = ~owner;
        end else begin
            pick = ~m_valid[0];
        end
    end

    assign s_valid  = !busy && (m_valid != 2'b00);
    assign s_req    = m_req[pick];
    assign accept   = s_valid && s_ready;

    assign m_ready[0] = !busy && s_ready && !pick;
    assign m_ready[1] = !busy && s_ready && pick;

    // only the owner sees the response
    assign rsp_ready      = busy && m_rsp_ready[owner];
    assign m_rsp_valid[0] = busy && rsp_valid && !owner;
    assign m_rsp_valid[1] = busy && rsp_valid && owner;
    assign rsp_done       = rsp_valid && rsp_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            // lsu counts as last owner so ifu wins the first tie
            owner <= 1'b1;
        end else if (accept) begin
            busy  <= 1'b1;
            owner <= pick;
        end else if (rsp_done) begin
            busy  <= 1'b0;
        end
    end

    // no response comes back unless a grant is held
    assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid |-> busy);

endmodule

`default_nettype wire

/* common/soc_bus_pkg.sv */
`default_nettype none

package soc_bus_pkg;

    // write address and data travel as one beat
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
    } bus_wr_req_t;

    typedef struct packed {
        logic [31:0] addr;
    } bus_rd_req_t;

    typedef struct packed {
        logic [1:0] resp;
    } bus_wr_rsp_t;

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
    } bus_rd_rsp_t;

    // byte-wise update of a word under write strobes
    function automatic logic [31:0] strb_merge(
        input logic [31:0] old_word,
        input logic [31:0] new_word,
        input logic [3:0]  strb
    );
        logic [31:0] merged;
        merged = old_word;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                merged[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return merged;
    endfunction

endpackage

`default_nettype wire

/* common/soc_bus_config.svh */
`ifndef SOC_BUS_CONFIG_SVH
`define SOC_BUS_CONFIG_SVH

`default_nettype none

// sram window is base plus depth in bytes
`define SOC_SRAM_BASE   32'h8000_0000
`define SOC_SRAM_WORDS  1024

// clint window is 8 bytes, mtime low at +0 and high at +4
`define SOC_CLINT_BASE  32'ha000_0048

// response codes
`define SOC_RESP_OKAY   2'b00
`define SOC_RESP_DECERR 2'b11

`default_nettype wire

`endif
